/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cx4
FILELIST  = cx4_dma.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/tb_cx4.sv */
`timescale 1ns/10ps

module tb_cx4;

  localparam int          MAX_CYCLES  = 20000;
  localparam logic [12:0] MMIO_BASE   = 13'h1f40;
  localparam logic [12:0] STATUS_ADDR = 13'h1f53;

  logic               CLK;
  logic               rst;
  cx4_pkg::byte_t     DI;
  cx4_pkg::byte_t     DO;
  logic [12:0]        ADDR;
  logic               CS;
  logic               nRD;
  logic               nWR;
  cx4_pkg::byte_t     BUS_DI;
  cx4_pkg::bus_addr_t BUS_ADDR;
  logic               BUS_RRQ;
  logic               BUS_RDY;
  logic               cx4_active;

  integer             seed = 38;
  integer             delay_seed = 38;  // bus model draws apart from the stimulus
  integer             errors = 0;
  integer             cycles = 0;
  cx4_pkg::byte_t     model_ram [0:3071];
  bit                 known [0:3071];  // bytes with a known expected value
  cx4_pkg::byte_t     model_reg [0:31];
  cx4_pkg::bus_addr_t run_src;
  integer             req_idx;
  integer             rdy_wait;
  logic               req_open;

  cx4_top #(
    .WR_SYNC_LEN(6),
    .DATRAM_AW  (12)
  ) i_dut (
    .CLK       (CLK),
    .rst       (rst),
    .DI        (DI),
    .DO        (DO),
    .ADDR      (ADDR),
    .CS        (CS),
    .nRD       (nRD),
    .nWR       (nWR),
    .BUS_DI    (BUS_DI),
    .BUS_ADDR  (BUS_ADDR),
    .BUS_RRQ   (BUS_RRQ),
    .BUS_RDY   (BUS_RDY),
    .cx4_active(cx4_active)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge CLK);
      cycles = cycles + 1;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("%0d errors in %0d cycles", errors, cycles);
    $display("Checks failed");
    $finish;
  end

  function automatic cx4_pkg::bus_addr_t map_addr(input cx4_pkg::bus_addr_t src);
    return {1'b0, src[23:16], src[14:0]};  // bit 15 is not on the bus
  endfunction

  function automatic cx4_pkg::byte_t bus_byte(input cx4_pkg::bus_addr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16];
  endfunction

  function automatic cx4_pkg::byte_t reg_mask(input logic [4:0] off);
    case (off)
      5'h06:        return 8'h0f;  // target is 12 bits
      5'h07:        return 8'h00;
      5'h10:        return 8'h77;
      5'h11, 5'h12: return 8'h01;
      default:      return 8'hff;
    endcase
  endfunction

  task automatic check(input string name, input logic [23:0] got, input logic [23:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("error %s: got %0h, expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  //////////////////////////////
  // external bus memory
  always @(negedge CLK) begin
    if (BUS_RRQ) begin
      check("BUS_ADDR", BUS_ADDR, map_addr(run_src + 24'(req_idx)));
      req_idx  = req_idx + 1;
      BUS_RDY  = 1'b0;
      BUS_DI   = bus_byte(BUS_ADDR);
      rdy_wait = $unsigned($random(delay_seed)) % 4;
      req_open = 1'b1;
    end else if (req_open) begin
      if (rdy_wait == 0) begin
        BUS_RDY  = 1'b1;  // held until the next request
        req_open = 1'b0;
      end else begin
        rdy_wait = rdy_wait - 1;
      end
    end
  end

  //////////////////////////////
  // host bus
  task automatic host_write(input logic [12:0] addr, input cx4_pkg::byte_t data);
    @(negedge CLK);
    ADDR = addr;
    DI   = data;
    CS   = 1'b1;
    nWR  = 1'b0;
    repeat (6) @(negedge CLK);
    nWR = 1'b1;
    repeat (3) @(negedge CLK);  // write has landed
    CS = 1'b0;
  endtask

  task automatic read_expect(input logic [12:0] addr, input cx4_pkg::byte_t exp);
    @(negedge CLK);
    ADDR = addr;
    CS   = 1'b1;
    @(negedge CLK);
    check($sformatf("DO[%h]", addr), 24'(DO), 24'(exp));
    CS = 1'b0;
  endtask

  task automatic reg_write(input logic [4:0] off, input cx4_pkg::byte_t data);
    host_write(MMIO_BASE + 13'(off), data);
    model_reg[off] = data & reg_mask(off);
  endtask

  task automatic sweep_ram();
    for (int a = 0; a < 3072; a++) begin
      if (known[a]) begin
        read_expect(13'(a), model_ram[a]);
      end
    end
  endtask

  task automatic run_dma(input cx4_pkg::bus_addr_t src, input cx4_pkg::dram_addr_t tgt,
                         input cx4_pkg::dma_len_t len);
    run_src = src;
    req_idx = 0;
    reg_write(5'h00, src[7:0]);
    reg_write(5'h01, src[15:8]);
    reg_write(5'h02, src[23:16]);
    reg_write(5'h03, len[7:0]);
    reg_write(5'h04, len[15:8]);
    reg_write(5'h05, tgt[7:0]);
    reg_write(5'h06, {4'h0, tgt[11:8]});
    reg_write(5'h07, 8'h00);  // starts the engine
    while (!cx4_active) @(negedge CLK);
    read_expect(STATUS_ADDR, 8'h40);
    check("cx4_active", 24'(cx4_active), 24'h1);
    while (cx4_active) @(negedge CLK);
    check("BUS_RRQ count", 24'(req_idx), 24'(len));
    for (int i = 0; i < int'(len); i++) begin
      model_ram[int'(tgt) + i] = bus_byte(map_addr(src + 24'(i)));
      known[int'(tgt) + i]     = 1'b1;
    end
    for (int i = 0; i < int'(len); i++) begin
      read_expect(13'(int'(tgt) + i), model_ram[int'(tgt) + i]);
    end
  endtask

  //////////////////////////////
  // test sequence
  initial begin
    cx4_pkg::dram_addr_t a;
    cx4_pkg::byte_t      d;
    cx4_pkg::bus_addr_t  src [4];
    cx4_pkg::dram_addr_t tgt [4];
    cx4_pkg::dma_len_t   len [4];
    rst      = 1'b1;
    DI       = 8'h00;
    ADDR     = 13'h0000;
    CS       = 1'b0;
    nRD      = 1'b1;
    nWR      = 1'b1;
    BUS_DI   = 8'h00;
    BUS_RDY  = 1'b0;
    run_src  = 24'h0;
    req_idx  = 0;
    rdy_wait = 0;
    req_open = 1'b0;
    for (int r = 0; r < 32; r++) begin
      model_reg[r] = 8'h00;
    end
    model_reg[16] = 8'h33;
    model_reg[18] = 8'h01;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    rst = 1'b0;

    check("BUS_RRQ", 24'(BUS_RRQ), 24'h0);
    check("cx4_active", 24'(cx4_active), 24'h0);
    read_expect(STATUS_ADDR, 8'h02);
    read_expect(MMIO_BASE + 13'h10, 8'h33);
    read_expect(MMIO_BASE + 13'h11, 8'h00);
    read_expect(MMIO_BASE + 13'h12, 8'h01);
    read_expect(MMIO_BASE + 13'h0a, 8'hff);  // no register there

    for (int n = 0; n < 40; n++) begin
      a = 12'($unsigned($random(seed)) % 32'hc00);
      d = 8'($random(seed));
      host_write({1'b0, a}, d);
      model_ram[a] = d;
      known[a]     = 1'b1;
    end
    sweep_ram();

    for (int r = 0; r < 19; r++) begin
      if (r < 7 || r > 15) begin  // DMATGT_H would start a transfer
        reg_write(5'(r), 8'($random(seed)));
        read_expect(MMIO_BASE + 13'(r), model_reg[r]);
      end
    end
    read_expect(MMIO_BASE + 13'h07, 8'h00);

    for (int k = 0; k < 4; k++) begin
      src[k] = 24'($random(seed));
      tgt[k] = 12'($unsigned($random(seed)) % 32'hb00);
      len[k] = 16'(1 + $unsigned($random(seed)) % 64);
    end
    run_dma(src[0], tgt[0], len[0]);

    // guard bytes around the next targets
    for (int k = 1; k < 4; k++) begin
      d = 8'($random(seed));
      if (tgt[k] != 12'h000) begin
        host_write({1'b0, tgt[k] - 12'h001}, d);
        model_ram[tgt[k] - 12'h001] = d;
        known[tgt[k] - 12'h001]     = 1'b1;
      end
      host_write({1'b0, tgt[k] + len[k][11:0]}, ~d);
      model_ram[tgt[k] + len[k][11:0]] = ~d;
      known[tgt[k] + len[k][11:0]]     = 1'b1;
    end
    for (int k = 1; k < 4; k++) begin
      run_dma(src[k], tgt[k], len[k]);
    end
    sweep_ram();

    $display("%0d errors in %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* common/cx4_pkg.sv */
package cx4_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [23:0] bus_addr_t;
  typedef logic [11:0] dram_addr_t;
  typedef logic [15:0] dma_len_t;

  localparam dram_addr_t DATRAM_LIMIT = 12'hc00;  // first offset past data RAM
  localparam logic [7:0] MMIO_PAGE    = 8'hfa;    // ADDR[12:5] of 0x1f40..0x1f5f
  localparam logic [4:0] STATUS_FIRST = 5'h13;

  typedef enum logic [4:0] {
    DMASRC_L = 5'h00,
    DMASRC_M = 5'h01,
    DMASRC_H = 5'h02,
    DMALEN_L = 5'h03,
    DMALEN_H = 5'h04,
    DMATGT_L = 5'h05,
    DMATGT_M = 5'h06,
    DMATGT_H = 5'h07,  // writing this one kicks off DMA
    MISC0    = 5'h10,
    MISC1    = 5'h11,
    MISC2    = 5'h12
  } mmio_reg_e;

  localparam byte_t MISC0_MASK  = 8'h77;
  localparam byte_t MISC0_RESET = 8'h33;
  localparam byte_t MMIO_UNUSED = 8'hff;

  typedef enum logic [3:0] {
    IDLE  = 4'b0001,
    START = 4'b0010,
    WAIT  = 4'b0100,
    ADDR  = 4'b1000
  } dma_state_e;

  typedef struct packed {
    logic datram;
    logic mmio;
    logic status;
    logic none;
  } region_t;

endpackage

/* common/dma_cfg_if.sv */
`timescale 1ns/10ps

interface dma_cfg_if;
  cx4_pkg::bus_addr_t  src;
  cx4_pkg::dma_len_t   len;
  cx4_pkg::dram_addr_t tgt;
  logic                start;  // one cycle

  modport regs (
    output src, len, tgt, start
  );

  modport engine (
    input src, len, tgt, start
  );

endinterface

/* common/ram_port_if.sv */
`timescale 1ns/10ps

interface ram_port_if;
  logic                we;
  cx4_pkg::dram_addr_t addr;
  cx4_pkg::byte_t      din;
  cx4_pkg::byte_t      dout;  // registered read data

  modport user (
    output we, addr, din,
    input  dout
  );

  modport mem (
    input  we, addr, din,
    output dout
  );

endinterface

/* cx4_dma.f */
common/cx4_pkg.sv
common/dma_cfg_if.sv
common/ram_port_if.sv
dma/cx4_dma.sv
source/cx4_datram.sv
source/cx4_mmio_regs.sv
source/cx4_host_decode.sv
source/cx4_top.sv
bench/tb_cx4.sv

/* dma/cx4_dma.sv */
`timescale 1ns/10ps

module cx4_dma (
  input  logic               CLK,
  input  logic               rst,
  dma_cfg_if.engine          cfg,
  ram_port_if.user           ram,
  input  cx4_pkg::byte_t     BUS_DI,
  input  logic               BUS_RDY,
  output cx4_pkg::bus_addr_t BUS_ADDR,
  output logic               BUS_RRQ,
  output logic               busy
);

  cx4_pkg::dma_state_e state;
  cx4_pkg::bus_addr_t  src_addr;
  cx4_pkg::dram_addr_t tgt_addr;
  cx4_pkg::dma_len_t   count;
  logic                ram_we;
  logic                byte_ok;

  assign BUS_ADDR = {1'b0, src_addr[23:16], src_addr[14:0]};  // bit 15 skipped
  assign byte_ok  = (state == cx4_pkg::WAIT) && !BUS_RRQ && BUS_RDY;

  assign ram.we   = ram_we;
  assign ram.addr = tgt_addr;
  assign ram.din  = BUS_DI;

  //////////////////////////////
  // control FSM
  always_ff @(posedge CLK) begin
    if (rst) begin
      state    <= cx4_pkg::IDLE;
      busy     <= 1'b0;
      BUS_RRQ  <= 1'b0;
      ram_we   <= 1'b0;
      src_addr <= '0;
    end else begin
      case (state)
        cx4_pkg::IDLE: begin
          if (cfg.start) state <= cx4_pkg::START;
        end
        cx4_pkg::START: begin
          busy     <= 1'b1;
          src_addr <= cfg.src;
          BUS_RRQ  <= 1'b1;
          state    <= cx4_pkg::WAIT;
        end
        cx4_pkg::WAIT: begin
          BUS_RRQ <= 1'b0;
          if (byte_ok) begin
            ram_we <= 1'b1;
            state  <= cx4_pkg::ADDR;
          end
        end
        cx4_pkg::ADDR: begin
          ram_we   <= 1'b0;
          src_addr <= src_addr + 1'b1;
          if (count == '0) begin
            busy  <= 1'b0;
            state <= cx4_pkg::IDLE;
          end else begin
            BUS_RRQ <= 1'b1;  // next byte
            state   <= cx4_pkg::WAIT;
          end
        end
        default: state <= cx4_pkg::IDLE;
      endcase
    end
  end

  // count and target
  always_ff @(posedge CLK) begin
    if (state == cx4_pkg::START) begin
      count    <= cfg.len;
      tgt_addr <= cfg.tgt;
    end else begin
      if (byte_ok) count <= count - 1'b1;
      if (state == cx4_pkg::ADDR) tgt_addr <= tgt_addr + 1'b1;
    end
  end

  a_rrq_single: assert property (@(posedge CLK) disable iff (rst)
    BUS_RRQ |=> !BUS_RRQ);

  a_we_busy: assert property (@(posedge CLK) disable iff (rst)
    ram.we |-> busy);

endmodule

/* source/cx4_datram.sv */
`timescale 1ns/10ps

module cx4_datram #(
  parameter int DATRAM_AW = 12
) (
  input  logic    CLK,
  ram_port_if.mem a,  // host
  ram_port_if.mem b   // DMA
);

  localparam int DEPTH = 2 ** DATRAM_AW;

  cx4_pkg::byte_t mem [DEPTH];

  logic [DATRAM_AW-1:0] a_idx;
  logic [DATRAM_AW-1:0] b_idx;

  assign a_idx = a.addr[DATRAM_AW-1:0];
  assign b_idx = b.addr[DATRAM_AW-1:0];

  always_ff @(posedge CLK) begin
    if (a.we) begin
      mem[a_idx] <= a.din;
    end
    if (b.we) begin
      mem[b_idx] <= b.din;
    end
    a.dout <= mem[a_idx];  // read before write
    b.dout <= mem[b_idx];
  end

endmodule

/* source/cx4_host_decode.sv */
`timescale 1ns/10ps

module cx4_host_decode #(
  parameter int WR_SYNC_LEN = 6
) (
  input  logic           CLK,
  input  logic           rst,
  input  cx4_pkg::byte_t DI,
  input  logic [12:0]    ADDR,
  input  logic           CS,
  input  logic           nWR,
  input  logic           busy,
  output cx4_pkg::byte_t DO,
  ram_port_if.user       host_ram,
  output logic           mmio_wr,
  output logic [4:0]     mmio_offset,
  output cx4_pkg::byte_t mmio_data,
  input  cx4_pkg::byte_t mmio_rdata
);

  cx4_pkg::region_t         region;
  logic                     mmio_page;
  logic [WR_SYNC_LEN-1:0]   nwr_sreg;
  logic                     wr_en;
  cx4_pkg::byte_t           di_r;
  cx4_pkg::byte_t           status_do;

  //////////////////////////////
  // region decode
  assign mmio_page     = CS && (ADDR[12:5] == cx4_pkg::MMIO_PAGE);
  assign region.datram = CS && (ADDR[11:0] < cx4_pkg::DATRAM_LIMIT);
  assign region.mmio   = mmio_page && (ADDR[4:0] < cx4_pkg::STATUS_FIRST);
  assign region.status = mmio_page && (ADDR[4:0] >= cx4_pkg::STATUS_FIRST);
  assign region.none   = !(region.datram || region.mmio || region.status);

  //////////////////////////////
  // write strobe filter
  always_ff @(posedge CLK) begin
    if (rst) begin
      nwr_sreg <= '1;
    end else begin
      nwr_sreg <= {nwr_sreg[WR_SYNC_LEN-2:0], nWR};
    end
  end

  // rising nWR after WR_SYNC_LEN-1 low samples
  assign wr_en = (nwr_sreg == {{(WR_SYNC_LEN-1){1'b0}}, 1'b1});

  always_ff @(posedge CLK) begin
    di_r <= DI;
  end

  assign host_ram.we   = region.datram && wr_en;
  assign host_ram.addr = ADDR[11:0];
  assign host_ram.din  = di_r;

  assign mmio_wr     = region.mmio && wr_en;
  assign mmio_offset = ADDR[4:0];
  assign mmio_data   = di_r;

  assign status_do = {1'b0, busy, 4'b0000, ~busy, 1'b0};

  //////////////////////////////
  // read mux
  always_comb begin
    if (region.datram) DO = host_ram.dout;
    else if (region.mmio) DO = mmio_rdata;
    else if (region.status) DO = status_do;
    else DO = 8'h00;  // region.none
  end

  a_region_onehot: assert property (@(posedge CLK) disable iff (rst)
    $onehot(region));

endmodule

/* source/cx4_mmio_regs.sv */
`timescale 1ns/10ps

module cx4_mmio_regs (
  input  logic           CLK,
  input  logic           rst,
  input  logic           wr,
  input  logic [4:0]     offset,
  input  cx4_pkg::byte_t data,
  output cx4_pkg::byte_t rdata,
  dma_cfg_if.regs        cfg
);

  cx4_pkg::bus_addr_t  dma_src;
  cx4_pkg::dma_len_t   dma_len;
  cx4_pkg::dram_addr_t dma_tgt;
  cx4_pkg::byte_t      misc0;
  logic                misc1;
  logic                misc2;

  assign cfg.src = dma_src;
  assign cfg.len = dma_len;
  assign cfg.tgt = dma_tgt;

  //////////////////////////////
  // register writes
  always_ff @(posedge CLK) begin
    if (rst) begin
      dma_src   <= '0;
      dma_len   <= '0;
      dma_tgt   <= '0;
      misc0     <= cx4_pkg::MISC0_RESET;
      misc1     <= 1'b0;
      misc2     <= 1'b1;
      cfg.start <= 1'b0;
    end else begin
      cfg.start <= wr && (offset == cx4_pkg::DMATGT_H);
      if (wr) begin
        case (cx4_pkg::mmio_reg_e'(offset))
          cx4_pkg::DMASRC_L: dma_src[7:0]   <= data;
          cx4_pkg::DMASRC_M: dma_src[15:8]  <= data;
          cx4_pkg::DMASRC_H: dma_src[23:16] <= data;
          cx4_pkg::DMALEN_L: dma_len[7:0]   <= data;
          cx4_pkg::DMALEN_H: dma_len[15:8]  <= data;
          cx4_pkg::DMATGT_L: dma_tgt[7:0]   <= data;
          cx4_pkg::DMATGT_M: dma_tgt[11:8]  <= data[3:0];  // upper bits dropped
          cx4_pkg::MISC0:    misc0 <= data & cx4_pkg::MISC0_MASK;
          cx4_pkg::MISC1:    misc1 <= data[0];
          cx4_pkg::MISC2:    misc2 <= data[0];
          default: ;  // DMATGT_H only triggers
        endcase
      end
    end
  end

  //////////////////////////////
  // read back, one cycle late
  always_ff @(posedge CLK) begin
    case (cx4_pkg::mmio_reg_e'(offset))
      cx4_pkg::DMASRC_L: rdata <= dma_src[7:0];
      cx4_pkg::DMASRC_M: rdata <= dma_src[15:8];
      cx4_pkg::DMASRC_H: rdata <= dma_src[23:16];
      cx4_pkg::DMALEN_L: rdata <= dma_len[7:0];
      cx4_pkg::DMALEN_H: rdata <= dma_len[15:8];
      cx4_pkg::DMATGT_L: rdata <= dma_tgt[7:0];
      cx4_pkg::DMATGT_M: rdata <= {4'b0000, dma_tgt[11:8]};
      cx4_pkg::DMATGT_H: rdata <= 8'h00;
      cx4_pkg::MISC0:    rdata <= misc0;
      cx4_pkg::MISC1:    rdata <= {7'b0, misc1};
      cx4_pkg::MISC2:    rdata <= {7'b0, misc2};
      default:           rdata <= cx4_pkg::MMIO_UNUSED;
    endcase
  end

endmodule

/* source/cx4_top.sv */
`timescale 1ns/10ps

module cx4_top #(
  parameter int WR_SYNC_LEN = 6,
  parameter int DATRAM_AW   = 12
) (
  input  logic               CLK,
  input  logic               rst,
  input  cx4_pkg::byte_t     DI,
  output cx4_pkg::byte_t     DO,
  input  logic [12:0]        ADDR,
  input  logic               CS,
  input  logic               nRD,  // pin compatibility only
  input  logic               nWR,
  input  cx4_pkg::byte_t     BUS_DI,
  output cx4_pkg::bus_addr_t BUS_ADDR,
  output logic               BUS_RRQ,
  input  logic               BUS_RDY,
  output logic               cx4_active
);

  dma_cfg_if  dma_cfg ();
  ram_port_if host_ram ();
  ram_port_if dma_ram ();

  logic           mmio_wr;
  logic [4:0]     mmio_offset;
  cx4_pkg::byte_t mmio_data;
  cx4_pkg::byte_t mmio_rdata;

  //////////////////////////////
  // host side
  cx4_host_decode #(
    .WR_SYNC_LEN(WR_SYNC_LEN)
  ) i_host_decode (
    .CLK        (CLK),
    .rst        (rst),
    .DI         (DI),
    .ADDR       (ADDR),
    .CS         (CS),
    .nWR        (nWR),
    .busy       (cx4_active),
    .DO         (DO),
    .host_ram   (host_ram.user),
    .mmio_wr    (mmio_wr),
    .mmio_offset(mmio_offset),
    .mmio_data  (mmio_data),
    .mmio_rdata (mmio_rdata)
  );

  cx4_mmio_regs i_mmio_regs (
    .CLK   (CLK),
    .rst   (rst),
    .wr    (mmio_wr),
    .offset(mmio_offset),
    .data  (mmio_data),
    .rdata (mmio_rdata),
    .cfg   (dma_cfg.regs)
  );

  //////////////////////////////
  // memory and DMA
  cx4_datram #(
    .DATRAM_AW(DATRAM_AW)
  ) i_datram (
    .CLK(CLK),
    .a  (host_ram.mem),
    .b  (dma_ram.mem)
  );

  cx4_dma i_dma (
    .CLK     (CLK),
    .rst     (rst),
    .cfg     (dma_cfg.engine),
    .ram     (dma_ram.user),
    .BUS_DI  (BUS_DI),
    .BUS_RDY (BUS_RDY),
    .BUS_ADDR(BUS_ADDR),
    .BUS_RRQ (BUS_RRQ),
    .busy    (cx4_active)  // only DMA can be busy now
  );

endmodule
